// ==== hdl/rv32_cfg.svh ====
`ifndef RV32_CFG_SVH
`define RV32_CFG_SVH

// data and address width
`define RV32_XLEN 32

// architectural register file
`define RV32_NUM_REGS 32
`define RV32_REG_ADDR_W 5

// first instruction fetched after reset
`define RV32_PC_START 32'h20400000

`endif

// ==== hdl/rv32_pkg.sv ====
`include "rv32_cfg.svh"

package rv32_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_cond_t;

    typedef enum logic {OP1_RS1, OP1_PC} op1_sel_t;

    typedef enum logic [1:0] {OP2_RS2, OP2_IMM, OP2_SHAMT} op2_sel_t;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_IMM, WB_LINK} wb_sel_t;

    typedef enum logic [2:0] {
        ST_FETCH, ST_WAIT_FETCH, ST_DECODE, ST_EXECUTE, ST_WRITEBACK
    } core_stage_t;

    typedef struct packed {
        logic [`RV32_REG_ADDR_W-1:0] rs1;
        logic [`RV32_REG_ADDR_W-1:0] rs2;
        logic [`RV32_REG_ADDR_W-1:0] rd;
        logic [`RV32_XLEN-1:0]       imm;
        alu_op_t                     alu_op;
        op1_sel_t                    op1_sel;
        op2_sel_t                    op2_sel;
        wb_sel_t                     wb_sel;
        branch_cond_t                branch_cond;
        logic                        is_jump;
        logic                        is_jalr;
    } decoded_instr_t;

    // registered ALU output plus rs1/rs2 compare flags
    typedef struct packed {
        logic [`RV32_XLEN-1:0] result;
        logic                  eq;
        logic                  lt;
        logic                  ltu;
    } alu_result_t;

endpackage

// ==== hdl/fetch_bus_master.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module fetch_bus_master (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_fetch_req,
    input  logic [`RV32_XLEN-1:0] i_fetch_addr,
    input  logic                  i_ack,
    input  logic                  i_stall,
    input  logic [`RV32_XLEN-1:0] i_data,
    output logic                  o_cyc,
    output logic                  o_stb,
    output logic [`RV32_XLEN-1:0] o_addr,
    output logic                  o_fetch_done,
    output logic [`RV32_XLEN-1:0] o_fetch_data
);

    logic                  pending;
    logic [`RV32_XLEN-1:0] pend_addr;
    logic                  start;

    // a request may only go out on a free, unstalled bus
    assign start = (i_fetch_req || pending) && !o_cyc && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_fetch_req) begin
            pend_addr <= i_fetch_addr;
        end
        if (o_cyc && i_ack && !i_stall) begin
            o_fetch_data <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending      <= 1'b0;
            o_cyc        <= 1'b0;
            o_stb        <= 1'b0;
            o_addr       <= '0;
            o_fetch_done <= 1'b0;
        end else begin
            // strobe and done are single-cycle pulses
            o_stb        <= 1'b0;
            o_fetch_done <= 1'b0;
            if (start) begin
                o_cyc   <= 1'b1;
                o_stb   <= 1'b1;
                o_addr  <= i_fetch_req ? i_fetch_addr : pend_addr;
                pending <= 1'b0;
            end else if (i_fetch_req) begin
                pending <= 1'b1;
            end
            if (o_cyc && i_ack && !i_stall) begin
                o_cyc        <= 1'b0;
                o_addr       <= '0;
                o_fetch_done <= 1'b1;
            end
        end
    end

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst) o_stb |-> o_cyc);

    // control only asks for the next word after the last one came back
    a_no_req_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        i_fetch_req |-> !o_cyc);

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module instr_decoder (
    input  logic [`RV32_XLEN-1:0]  i_instr,
    output rv32_pkg::decoded_instr_t o_dec
);

    import rv32_pkg::*;

    opcode_t    opc;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       shift_ok;
    logic       op_ok;

    // funct3 plus the alternate bit (instr[30]) onto an ALU operation
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opc    = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    // legal funct7 for the shift-immediates and the register ops
    assign shift_ok = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && funct3 == 3'b101);
    assign op_ok    = (funct7 == 7'b0000000) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        o_dec.rs1         = i_instr[19:15];
        o_dec.rs2         = i_instr[24:20];
        o_dec.rd          = i_instr[11:7];
        // I-type by default
        o_dec.imm         = {{20{i_instr[31]}}, i_instr[31:20]};
        o_dec.alu_op      = ALU_ADD;
        o_dec.op1_sel     = OP1_RS1;
        o_dec.op2_sel     = OP2_IMM;
        o_dec.wb_sel      = WB_NONE;
        o_dec.branch_cond = BR_NONE;
        o_dec.is_jump     = 1'b0;
        o_dec.is_jalr     = 1'b0;

        case (opc)
            OPC_LUI: begin
                o_dec.imm    = {i_instr[31:12], 12'b0};
                o_dec.wb_sel = WB_IMM;
            end
            OPC_AUIPC: begin
                o_dec.imm     = {i_instr[31:12], 12'b0};
                o_dec.op1_sel = OP1_PC;
                o_dec.wb_sel  = WB_ALU;
            end
            OPC_JAL: begin
                o_dec.imm     = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                                 i_instr[30:21], 1'b0};
                o_dec.op1_sel = OP1_PC;
                o_dec.wb_sel  = WB_LINK;
                o_dec.is_jump = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    o_dec.wb_sel  = WB_LINK;
                    o_dec.is_jump = 1'b1;
                    o_dec.is_jalr = 1'b1;
                end
            end
            OPC_BRANCH: begin
                o_dec.imm     = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                                 i_instr[11:8], 1'b0};
                o_dec.op1_sel = OP1_PC;
                case (funct3)
                    3'b000:  o_dec.branch_cond = BR_EQ;
                    3'b001:  o_dec.branch_cond = BR_NE;
                    3'b100:  o_dec.branch_cond = BR_LT;
                    3'b101:  o_dec.branch_cond = BR_GE;
                    3'b110:  o_dec.branch_cond = BR_LTU;
                    3'b111:  o_dec.branch_cond = BR_GEU;
                    default: o_dec.branch_cond = BR_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    o_dec.op2_sel = OP2_SHAMT;
                    o_dec.alu_op  = alu_sel(funct3, funct7[5]);
                    o_dec.wb_sel  = shift_ok ? WB_ALU : WB_NONE;
                end else begin
                    o_dec.alu_op = alu_sel(funct3, 1'b0);
                    o_dec.wb_sel = WB_ALU;
                end
            end
            OPC_OP: begin
                o_dec.op2_sel = OP2_RS2;
                o_dec.alu_op  = alu_sel(funct3, funct7[5]);
                o_dec.wb_sel  = op_ok ? WB_ALU : WB_NONE;
            end
            OPC_MISC_MEM, OPC_SYSTEM: begin
                // fence, ecall, ebreak and csr retire as no-ops
                o_dec.wb_sel = WB_NONE;
            end
            default: begin
                o_dec.wb_sel = WB_NONE;
            end
        endcase
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module reg_file (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic [`RV32_REG_ADDR_W-1:0] i_rs1,
    input  logic [`RV32_REG_ADDR_W-1:0] i_rs2,
    input  logic                        i_we,
    input  logic [`RV32_REG_ADDR_W-1:0] i_rd,
    input  logic [`RV32_XLEN-1:0]       i_wdata,
    output logic [`RV32_XLEN-1:0]       o_rs1_data,
    output logic [`RV32_XLEN-1:0]       o_rs2_data,
    output logic                        o_x10_bit0
);

    logic [`RV32_XLEN-1:0] regs [`RV32_NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RV32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 is never written, so its storage reads as zero
    assign o_rs1_data = regs[i_rs1];
    assign o_rs2_data = regs[i_rs2];

    // debug led
    assign o_x10_bit0 = regs[10][0];

    a_x0_zero: assert property (@(posedge i_clk) disable iff (i_rst) regs[0] == '0);

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module alu (
    input  logic                  i_clk,
    input  rv32_pkg::alu_op_t     i_op,
    input  logic [`RV32_XLEN-1:0] i_op1,
    input  logic [`RV32_XLEN-1:0] i_op2,
    input  logic [`RV32_XLEN-1:0] i_cmp_a,
    input  logic [`RV32_XLEN-1:0] i_cmp_b,
    output rv32_pkg::alu_result_t o_res
);

    import rv32_pkg::*;

    logic [`RV32_XLEN-1:0] result;
    logic [4:0]            shamt;

    // only the low 5 bits of a shift amount count
    assign shamt = i_op2[4:0];

    always_comb begin
        case (i_op)
            ALU_ADD:  result = i_op1 + i_op2;
            ALU_SUB:  result = i_op1 - i_op2;
            ALU_SLT:  result = {{(`RV32_XLEN-1){1'b0}}, $signed(i_op1) < $signed(i_op2)};
            ALU_SLTU: result = {{(`RV32_XLEN-1){1'b0}}, i_op1 < i_op2};
            ALU_XOR:  result = i_op1 ^ i_op2;
            ALU_OR:   result = i_op1 | i_op2;
            ALU_AND:  result = i_op1 & i_op2;
            ALU_SLL:  result = i_op1 << shamt;
            ALU_SRL:  result = i_op1 >> shamt;
            ALU_SRA:  result = $signed(i_op1) >>> shamt;
            default:  result = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        o_res.result <= result;
        // branch flags on the register operands
        o_res.eq     <= (i_cmp_a == i_cmp_b);
        o_res.lt     <= ($signed(i_cmp_a) < $signed(i_cmp_b));
        o_res.ltu    <= (i_cmp_a < i_cmp_b);
    end

endmodule

// ==== hdl/core_control.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module core_control (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic                           i_fetch_done,
    input  logic [`RV32_XLEN-1:0]          i_fetch_data,
    input  rv32_pkg::decoded_instr_t       i_dec,
    input  logic [`RV32_XLEN-1:0]          i_rs1_data,
    input  logic [`RV32_XLEN-1:0]          i_rs2_data,
    input  rv32_pkg::alu_result_t          i_alu,
    output logic                           o_fetch_req,
    output logic [`RV32_XLEN-1:0]          o_fetch_addr,
    output logic [`RV32_XLEN-1:0]          o_instr,
    output logic [`RV32_REG_ADDR_W-1:0]    o_rs1,
    output logic [`RV32_REG_ADDR_W-1:0]    o_rs2,
    output rv32_pkg::alu_op_t              o_alu_op,
    output logic [`RV32_XLEN-1:0]          o_op1,
    output logic [`RV32_XLEN-1:0]          o_op2,
    output logic [`RV32_XLEN-1:0]          o_cmp_a,
    output logic [`RV32_XLEN-1:0]          o_cmp_b,
    output logic                           o_we,
    output logic [`RV32_REG_ADDR_W-1:0]    o_rd,
    output logic [`RV32_XLEN-1:0]          o_wdata
);

    import rv32_pkg::*;

    core_stage_t           stage;
    logic [`RV32_XLEN-1:0] pc;
    logic [`RV32_XLEN-1:0] pc_plus4;
    logic [`RV32_XLEN-1:0] next_pc;
    decoded_instr_t        dec_r;
    logic                  taken;

    assign pc_plus4     = pc + 32'd4;
    assign o_fetch_req  = (stage == ST_FETCH);
    assign o_fetch_addr = pc;

    // operand selection
    assign o_rs1    = dec_r.rs1;
    assign o_rs2    = dec_r.rs2;
    assign o_alu_op = dec_r.alu_op;
    assign o_op1    = (dec_r.op1_sel == OP1_PC) ? pc : i_rs1_data;
    assign o_cmp_a  = i_rs1_data;
    assign o_cmp_b  = i_rs2_data;

    always_comb begin
        case (dec_r.op2_sel)
            OP2_RS2:   o_op2 = i_rs2_data;
            OP2_SHAMT: o_op2 = {{(`RV32_XLEN-5){1'b0}}, dec_r.imm[4:0]};
            default:   o_op2 = dec_r.imm;
        endcase
    end

    // writeback
    assign o_we = (stage == ST_WRITEBACK) && (dec_r.wb_sel != WB_NONE);
    assign o_rd = dec_r.rd;

    always_comb begin
        case (dec_r.wb_sel)
            WB_ALU:  o_wdata = i_alu.result;
            WB_IMM:  o_wdata = dec_r.imm;
            WB_LINK: o_wdata = pc_plus4;
            default: o_wdata = '0;
        endcase
    end

    always_comb begin
        case (dec_r.branch_cond)
            BR_EQ:   taken = i_alu.eq;
            BR_NE:   taken = !i_alu.eq;
            BR_LT:   taken = i_alu.lt;
            BR_GE:   taken = !i_alu.lt;
            BR_LTU:  taken = i_alu.ltu;
            BR_GEU:  taken = !i_alu.ltu;
            default: taken = 1'b0;
        endcase
    end

    // alu result holds pc+imm, or rs1+imm for jalr
    always_comb begin
        if (dec_r.is_jalr) begin
            next_pc = {i_alu.result[`RV32_XLEN-1:1], 1'b0};
        end else if (dec_r.is_jump || taken) begin
            next_pc = i_alu.result;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (stage == ST_WAIT_FETCH && i_fetch_done) begin
            o_instr <= i_fetch_data;
        end
        if (stage == ST_DECODE) begin
            dec_r <= i_dec;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage <= ST_FETCH;
            pc    <= `RV32_PC_START;
        end else begin
            case (stage)
                ST_FETCH:      stage <= ST_WAIT_FETCH;
                ST_WAIT_FETCH: stage <= i_fetch_done ? ST_DECODE : ST_WAIT_FETCH;
                ST_DECODE:     stage <= ST_EXECUTE;
                ST_EXECUTE:    stage <= ST_WRITEBACK;
                ST_WRITEBACK: begin
                    pc    <= next_pc;
                    stage <= ST_FETCH;
                end
                default:       stage <= ST_FETCH;
            endcase
        end
    end

    a_fetch_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        o_fetch_req |-> o_fetch_addr[1:0] == 2'b00);

endmodule

// ==== hdl/rv32_core.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module rv32_core (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_ack,
    input  logic                  i_stall,
    input  logic [`RV32_XLEN-1:0] i_data,
    output logic                  o_cyc,
    output logic                  o_stb,
    output logic [`RV32_XLEN-1:0] o_addr,
    output logic                  o_debug_led
);

    import rv32_pkg::*;

    logic                        fetch_req;
    logic [`RV32_XLEN-1:0]       fetch_addr;
    logic                        fetch_done;
    logic [`RV32_XLEN-1:0]       fetch_data;
    logic [`RV32_XLEN-1:0]       instr;
    decoded_instr_t              dec;
    logic [`RV32_REG_ADDR_W-1:0] rs1;
    logic [`RV32_REG_ADDR_W-1:0] rs2;
    logic [`RV32_XLEN-1:0]       rs1_data;
    logic [`RV32_XLEN-1:0]       rs2_data;
    alu_op_t                     alu_op;
    logic [`RV32_XLEN-1:0]       op1;
    logic [`RV32_XLEN-1:0]       op2;
    logic [`RV32_XLEN-1:0]       cmp_a;
    logic [`RV32_XLEN-1:0]       cmp_b;
    alu_result_t                 alu_res;
    logic                        we;
    logic [`RV32_REG_ADDR_W-1:0] rd;
    logic [`RV32_XLEN-1:0]       wdata;

    fetch_bus_master u_fetch (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fetch_req  (fetch_req),
        .i_fetch_addr (fetch_addr),
        .i_ack        (i_ack),
        .i_stall      (i_stall),
        .i_data       (i_data),
        .o_cyc        (o_cyc),
        .o_stb        (o_stb),
        .o_addr       (o_addr),
        .o_fetch_done (fetch_done),
        .o_fetch_data (fetch_data)
    );

    instr_decoder u_decoder (
        .i_instr (instr),
        .o_dec   (dec)
    );

    reg_file u_regs (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_we       (we),
        .i_rd       (rd),
        .i_wdata    (wdata),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_x10_bit0 (o_debug_led)
    );

    alu u_alu (
        .i_clk   (i_clk),
        .i_op    (alu_op),
        .i_op1   (op1),
        .i_op2   (op2),
        .i_cmp_a (cmp_a),
        .i_cmp_b (cmp_b),
        .o_res   (alu_res)
    );

    core_control u_control (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fetch_done (fetch_done),
        .i_fetch_data (fetch_data),
        .i_dec        (dec),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .i_alu        (alu_res),
        .o_fetch_req  (fetch_req),
        .o_fetch_addr (fetch_addr),
        .o_instr      (instr),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_alu_op     (alu_op),
        .o_op1        (op1),
        .o_op2        (op2),
        .o_cmp_a      (cmp_a),
        .o_cmp_b      (cmp_b),
        .o_we         (we),
        .o_rd         (rd),
        .o_wdata      (wdata)
    );

endmodule

// ==== bench/rv32_core_tb.sv ====
`timescale 1ns/1ns
`include "rv32_cfg.svh"

module rv32_core_tb;

    localparam logic [31:0] OPC_IMM   = 32'h13;
    localparam logic [31:0] OPC_LUI   = 32'h37;
    localparam logic [31:0] OPC_AUIPC = 32'h17;
    localparam logic [31:0] OPC_JALR  = 32'h67;

    logic        i_clk;
    logic        i_rst;
    logic        i_ack;
    logic        i_stall;
    logic [31:0] i_data;
    logic        o_cyc;
    logic        o_stb;
    logic [31:0] o_addr;
    logic        o_debug_led;

    // program memory and the expected fetch stream
    logic [31:0] prog [0:255];
    int          prog_len;
    logic [31:0] exp_addr [$];
    int          exp_led [$];

    logic [31:0] lcg_state;
    logic        stb_prev;
    logic        stall_prev;
    logic        ack_busy;
    int          ack_wait;
    logic [31:0] idx;
    logic [31:0] rd_word;

    rv32_core dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_ack       (i_ack),
        .i_stall     (i_stall),
        .i_data      (i_data),
        .o_cyc       (o_cyc),
        .o_stb       (o_stb),
        .o_addr      (o_addr),
        .o_debug_led (o_debug_led)
    );

    always #10 i_clk = ~i_clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    function automatic logic [31:0] addr_of(input int n);
        return `RV32_PC_START + 32'(n) * 32'd4;
    endfunction

    // instruction encoders
    function automatic logic [31:0] enc_r(input logic [31:0] f7, f3, rd, rs1, rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [31:0] imm, rs1, f3, rd, opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] f3, rs1, rs2, imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] opc, rd, imm);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(input logic [31:0] rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // reference branch rule on funct3
    function automatic bit branch_taken(input logic [31:0] f3, a, b);
        case (f3[2:0])
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // bus memory model answers each strobe with one word after a random delay
    always @(posedge i_clk) begin
        if (i_rst) begin
            i_ack    <= 1'b0;
            i_stall  <= 1'b0;
            ack_busy = 1'b0;
        end else begin
            // cycle open from the strobe through the accepted acknowledge
            assert (o_cyc == (o_stb || ack_busy || i_ack)) else fail_run($sformatf(
                "ERROR %0t: o_cyc %b outside the strobe to acknowledge window", $time, o_cyc));
            i_ack <= 1'b0;
            if (o_stb) begin
                assert (!stb_prev && !stall_prev) else fail_run($sformatf(
                    "ERROR %0t: strobe too long or launched under stall", $time));
                idx = (o_addr - `RV32_PC_START) >> 2;
                assert (idx < prog_len) else fail_run($sformatf(
                    "ERROR %0t: fetch outside the program at %h", $time, o_addr));
                rd_word  = prog[idx[7:0]];
                ack_wait = int'(lcg_next() % 32'd4);
                ack_busy = 1'b1;
            end
            if (ack_busy && ack_wait == 0) begin
                i_ack  <= 1'b1;
                i_data <= rd_word;
                // a stalled acknowledge is repeated until it goes through
                if ((lcg_next() % 32'd4) == 32'd0) begin
                    i_stall <= 1'b1;
                end else begin
                    i_stall  <= 1'b0;
                    ack_busy = 1'b0;
                end
            end else begin
                if (ack_busy) begin
                    ack_wait--;
                end
                i_stall <= (lcg_next() % 32'd4) == 32'd0;
            end
        end
        stb_prev   <= o_stb;
        stall_prev <= i_stall;
    end

    task automatic emit(input logic [31:0] w, input bit fetched = 1'b1, input int led = -1);
        if (fetched) begin
            exp_addr.push_back(addr_of(prog_len));
            exp_led.push_back(led);
        end
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic load_imm(input logic [31:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit(enc_u(OPC_LUI, rd, {12'd0, hi[31:12]}));
        emit(enc_i({20'd0, v[11:0]}, rd, 0, rd, OPC_IMM));
    endtask

    // beq against x4 skips a self-loop trap when the value matches
    task automatic check_reg(input logic [31:0] rs, input logic [31:0] expect_val);
        load_imm(4, expect_val);
        emit(enc_b(0, rs, 4, 8));
        emit(enc_j(0, 0), 1'b0);
    endtask

    task automatic alu_rr(input logic [31:0] f7, f3, rs1, rs2, expect_val);
        emit(enc_r(f7, f3, 3, rs1, rs2));
        check_reg(3, expect_val);
    endtask

    task automatic alu_ri(input logic [31:0] f3, imm, expect_val);
        emit(enc_i(imm, 1, f3, 3, OPC_IMM));
        check_reg(3, expect_val);
    endtask

    task automatic branch_case(input logic [31:0] f3, rs1, rs2, a, b);
        emit(enc_b(f3, rs1, rs2, 8));
        if (branch_taken(f3, a, b)) begin
            emit(enc_j(0, 0), 1'b0);
        end else begin
            emit(enc_i(0, 0, 0, 0, OPC_IMM));
        end
    endtask

    task automatic begin_program();
        i_rst <= 1'b1;
        @(posedge i_clk);
        prog_len = 0;
        exp_addr.delete();
        exp_led.delete();
    endtask

    task automatic wait_strobe(output logic [31:0] addr, output logic led);
        int n;
        n = 0;
        do begin
            @(posedge i_clk);
            n++;
        end while (!o_stb && n < 300);
        if (o_stb) begin
            addr = o_addr;
            led  = o_debug_led;
        end else begin
            fail_run("timeout while waiting for an instruction fetch strobe");
        end
    endtask

    task automatic run_program(input string name);
        logic [31:0] addr;
        logic        led;
        emit(enc_j(0, 0));
        repeat (7) begin
            @(posedge i_clk);
            assert (!o_cyc && !o_stb) else fail_run($sformatf(
                "ERROR %0t: bus active during reset", $time));
        end
        i_rst <= 1'b0;
        foreach (exp_addr[k]) begin
            wait_strobe(addr, led);
            assert (addr == exp_addr[k]) else fail_run($sformatf(
                "ERROR %0t: %s fetch %0d at %h, expected %h", $time, name, k, addr, exp_addr[k]));
            if (exp_led[k] >= 0) begin
                assert (led == exp_led[k][0]) else fail_run($sformatf(
                    "ERROR %0t: %s debug led %b, expected %0d", $time, name, led, exp_led[k]));
            end
        end
        $display("%s: %0d fetches compared", name, exp_addr.size());
    endtask

    task automatic test_reset_start();
        begin_program();
        emit(enc_i(7, 0, 0, 1, OPC_IMM));
        check_reg(1, 7);
        run_program("reset");
    endtask

    task automatic test_sequential();
        begin_program();
        repeat (12) emit(enc_i(3, 1, 0, 1, OPC_IMM));
        check_reg(1, 36);
        run_program("sequential");
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'h8765_4321;
        b = 32'h0000_0F23;
        begin_program();
        load_imm(1, a);
        load_imm(2, b);
        alu_rr(0, 0, 1, 2, a + b);
        alu_rr(32'h20, 0, 1, 2, a - b);
        alu_rr(0, 4, 1, 2, a ^ b);
        alu_rr(0, 6, 1, 2, a | b);
        alu_rr(0, 7, 1, 2, a & b);
        alu_rr(0, 1, 1, 2, a << b[4:0]);
        alu_rr(0, 5, 1, 2, a >> b[4:0]);
        alu_rr(32'h20, 5, 1, 2, $signed(a) >>> b[4:0]);
        alu_ri(0, -5, a + 32'hFFFF_FFFB);
        alu_ri(4, 32'h7F0, a ^ 32'h7F0);
        alu_ri(6, 32'h555, a | 32'h555);
        alu_ri(7, -16, a & 32'hFFFF_FFF0);
        alu_ri(1, 7, a << 7);
        alu_ri(5, 9, a >> 9);
        alu_ri(5, 32'h409, $signed(a) >>> 9);
        run_program("alu");
    endtask

    task automatic test_compare();
        logic [31:0] a;
        logic [31:0] b;
        int          conds [6];
        a     = -3;
        b     = 5;
        conds = '{0, 1, 4, 5, 6, 7};
        begin_program();
        load_imm(1, a);
        load_imm(2, b);
        alu_rr(0, 2, 1, 2, {31'd0, $signed(a) < $signed(b)});
        alu_rr(0, 3, 1, 2, {31'd0, a < b});
        alu_rr(0, 2, 2, 1, {31'd0, $signed(b) < $signed(a)});
        alu_rr(0, 3, 2, 1, {31'd0, b < a});
        alu_ri(2, -2, {31'd0, $signed(a) < -32'sd2});
        alu_ri(3, -1, {31'd0, a < 32'hFFFF_FFFF});
        foreach (conds[i]) begin
            branch_case(conds[i], 1, 2, a, b);
            branch_case(conds[i], 2, 1, b, a);
            branch_case(conds[i], 1, 1, a, a);
        end
        run_program("compare");
    endtask

    task automatic test_jumps();
        int          base;
        logic [31:0] pc_auipc;
        begin_program();
        base = prog_len;
        // jal forward, jalr back through an odd x1, then jump past the block
        emit(enc_j(1, 12));
        emit(enc_j(0, 16), 1'b0);
        emit(enc_j(0, 0), 1'b0);
        emit(enc_i(1, 1, 0, 1, OPC_IMM));
        emit(enc_i(0, 1, 0, 0, OPC_JALR));
        exp_addr.push_back(addr_of(base + 1));
        exp_led.push_back(-1);
        check_reg(1, addr_of(base) + 32'd5);
        emit(enc_u(OPC_LUI, 3, 32'hABCDE));
        check_reg(3, 32'hABCD_E000);
        pc_auipc = addr_of(prog_len);
        emit(enc_u(OPC_AUIPC, 3, 32'h12345));
        check_reg(3, pc_auipc + 32'h1234_5000);
        emit(enc_i(123, 0, 0, 0, OPC_IMM));
        check_reg(0, 0);
        run_program("jumps");
    endtask

    task automatic test_debug_led();
        begin_program();
        emit(enc_i(0, 0, 0, 0, OPC_IMM), 1'b1, 0);
        emit(enc_i(5, 0, 0, 10, OPC_IMM));
        emit(enc_i(0, 0, 0, 0, OPC_IMM), 1'b1, 1);
        emit(enc_i(6, 0, 0, 10, OPC_IMM));
        emit(enc_i(0, 0, 0, 0, OPC_IMM), 1'b1, 0);
        run_program("debug led");
    endtask

    initial begin
        i_clk      = 1'b0;
        i_rst      = 1'b1;
        i_ack      = 1'b0;
        i_stall    = 1'b0;
        i_data     = '0;
        lcg_state  = 32'd93;
        prog_len   = 0;
        stb_prev   = 1'b0;
        stall_prev = 1'b0;
        ack_busy   = 1'b0;
        ack_wait   = 0;
        test_reset_start();
        test_sequential();
        test_alu();
        test_compare();
        test_jumps();
        test_debug_led();
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== rv32_core.f ====
+incdir+hdl
hdl/rv32_pkg.sv
hdl/fetch_bus_master.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/core_control.sv
hdl/rv32_core.sv
bench/rv32_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f rv32_core.f \
    --top-module rv32_core_tb \
    -o rv32_core_sim

./obj_dir/rv32_core_sim
